/* hw/tracker_defines.svh */
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// coordinate widths, wide enough for a 720p raster
`define TRK_X_BITS 11
`define TRK_Y_BITS 10

`define TRK_CNT_BITS 21  // holds 1280*720 masked pixels
`define TRK_SUM_BITS 32  // coordinate sums over a full frame

`define TRK_DIV_STEPS 32  // one quotient bit per step, matches sum width

// apb byte offsets
`define TRK_ADDR_CTRL    8'h00
`define TRK_ADDR_STATUS  8'h04
`define TRK_ADDR_BOX_MIN 8'h08
`define TRK_ADDR_BOX_MAX 8'h0c
`define TRK_ADDR_COM     8'h10
`define TRK_ADDR_COUNT   8'h14

`endif

/* hw/tracker_pkg.sv */
`include "tracker_defines.svh"

package tracker_pkg;

  typedef logic [`TRK_X_BITS-1:0]   xcoord_t;  // horizontal pixel position
  typedef logic [`TRK_Y_BITS-1:0]   ycoord_t;  // vertical pixel position
  typedef logic [7:0]               chan_t;    // one color channel
  typedef logic [`TRK_CNT_BITS-1:0] count_t;
  typedef logic [`TRK_SUM_BITS-1:0] sum_t;
  typedef logic [2:0]               sel_t;     // channel select code

  typedef struct packed {
    logic        valid;
    xcoord_t     x;
    ycoord_t     y;
    logic [15:0] rgb565;  // r in 15:11, g in 10:5, b in 4:0
  } pix_in_t;

  typedef struct packed {
    logic    valid;
    logic    mask;  // pixel passed the threshold
    xcoord_t x;
    ycoord_t y;
  } mask_pix_t;

  typedef struct packed {
    sel_t  sel;
    chan_t lower;  // inclusive bounds
    chan_t upper;
  } track_cfg_t;

  typedef struct packed {
    count_t  count;
    xcoord_t min_x;
    ycoord_t min_y;
    xcoord_t max_x;
    ycoord_t max_y;
    sum_t    x_sum;
    sum_t    y_sum;
  } frame_stats_t;

  typedef struct packed {
    count_t  count;
    xcoord_t min_x;
    ycoord_t min_y;
    xcoord_t max_x;
    ycoord_t max_y;
    xcoord_t com_x;
    ycoord_t com_y;
    logic    empty;  // no pixel passed, box and center meaningless
  } track_result_t;

  typedef enum logic [1:0] {IDLE, DIV_X, DIV_Y, PUBLISH} ctrl_state_t;

endpackage

/* hw/apb_regs.sv */
`include "tracker_defines.svh"

module apb_regs import tracker_pkg::*; (
  input  logic          clk_pixel,
  input  logic          sys_rst,
  input  logic [7:0]    paddr,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  logic [31:0]   pwdata,
  output logic [31:0]   prdata,
  output logic          pready,
  output logic          pslverr,
  output track_cfg_t    cfg,
  input  track_result_t result,
  input  logic          result_valid,
  input  logic          drop
);

  track_result_t last;         // most recently published frame
  logic [7:0]    n_published;  // wraps
  logic [7:0]    n_dropped;
  logic          access;       // second phase of a transfer
  logic          mapped;
  logic          wr_ctrl;

  assign access  = psel && penable;
  assign wr_ctrl = access && pwrite && (paddr == `TRK_ADDR_CTRL);
  assign pready  = 1'b1;  // no wait states
  // only CTRL takes writes
  assign pslverr = access && (!mapped || (pwrite && paddr != `TRK_ADDR_CTRL));

  always_comb begin
    mapped = 1'b1;
    case (paddr)
      `TRK_ADDR_CTRL:    prdata = {8'd0, cfg.upper, cfg.lower, 5'd0, cfg.sel};
      `TRK_ADDR_STATUS:  prdata = {15'd0, last.empty, n_dropped, n_published};
      `TRK_ADDR_BOX_MIN: prdata = {6'd0, last.min_y, 5'd0, last.min_x};
      `TRK_ADDR_BOX_MAX: prdata = {6'd0, last.max_y, 5'd0, last.max_x};
      `TRK_ADDR_COM:     prdata = {6'd0, last.com_y, 5'd0, last.com_x};
      `TRK_ADDR_COUNT:   prdata = {11'd0, last.count};
      default: begin
        prdata = '0;
        mapped = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      cfg         <= '0;
      last        <= '0;  // status must read zero out of reset
      n_published <= '0;
      n_dropped   <= '0;
    end else begin
      if (wr_ctrl) begin
        cfg.sel   <= pwdata[2:0];
        cfg.lower <= pwdata[15:8];
        cfg.upper <= pwdata[23:16];
      end
      if (result_valid) begin
        last        <= result;
        n_published <= n_published + 8'd1;
      end
      if (drop) n_dropped <= n_dropped + 8'd1;
    end
  end

endmodule

/* hw/channel_mask.sv */
module channel_mask import tracker_pkg::*; (
  input  logic       clk_pixel,
  input  logic       sys_rst,
  input  track_cfg_t cfg,
  input  pix_in_t    pix_in,
  input  logic       frame_end,
  output mask_pix_t  mask_pix,
  output logic       frame_end_d
);

  logic signed [19:0] r_ext, g_ext, b_ext;  // widened channels, zero extended
  // stage 1: widened color and products
  logic               s1_valid;
  xcoord_t            s1_x;
  ycoord_t            s1_y;
  chan_t              s1_r, s1_g, s1_b;
  logic signed [19:0] s1_yr, s1_yg, s1_yb;
  logic signed [19:0] s1_crr, s1_crg, s1_crb;
  logic signed [19:0] s1_cbr, s1_cbg, s1_cbb;
  // stage 2: summed color space
  logic               s2_valid;
  xcoord_t            s2_x;
  ycoord_t            s2_y;
  chan_t              s2_r, s2_g, s2_b, s2_luma, s2_cr, s2_cb;
  logic signed [19:0] y_full, cr_full, cb_full;
  // stage 3: select and threshold
  chan_t              pick;
  logic               pick_ok;  // select code names a real channel
  logic               out_valid, out_mask;
  xcoord_t            out_x;
  ycoord_t            out_y;
  logic [1:0]         fe_pipe;  // frame end follows the pixel pipe

  // 5-6-5 to 8 bits by padding zero lsbs
  assign r_ext = {12'd0, pix_in.rgb565[15:11], 3'd0};
  assign g_ext = {12'd0, pix_in.rgb565[10:5], 2'd0};
  assign b_ext = {12'd0, pix_in.rgb565[4:0], 3'd0};

  // +128 rounds, >>> keeps the sign for the chroma terms
  assign y_full  = 20'sd16 + ((s1_yr + s1_yg + s1_yb + 20'sd128) >>> 8);
  assign cr_full = 20'sd128 + ((s1_crr - s1_crg - s1_crb + 20'sd128) >>> 8);
  assign cb_full = 20'sd128 + ((s1_cbb - s1_cbr - s1_cbg + 20'sd128) >>> 8);

  always_comb begin
    pick_ok = 1'b1;
    case (cfg.sel)
      3'd0: pick = s2_g;
      3'd1: pick = s2_r;
      3'd2: pick = s2_b;
      3'd4: pick = s2_luma;
      3'd5: pick = s2_cr;
      3'd6: pick = s2_cb;
      default: begin  // 3 and 7 never pass
        pick    = '0;
        pick_ok = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      s1_valid    <= 1'b0;
      s2_valid    <= 1'b0;
      out_valid   <= 1'b0;
      fe_pipe     <= '0;
      frame_end_d <= 1'b0;
    end else begin
      s1_valid    <= pix_in.valid;
      s2_valid    <= s1_valid;
      out_valid   <= s2_valid;
      fe_pipe     <= {fe_pipe[0], frame_end};
      frame_end_d <= fe_pipe[1];
    end
  end

  always_ff @(posedge clk_pixel) begin
    s1_x   <= pix_in.x;
    s1_y   <= pix_in.y;
    s1_r   <= r_ext[7:0];
    s1_g   <= g_ext[7:0];
    s1_b   <= b_ext[7:0];
    s1_yr  <= 20'sd66 * r_ext;
    s1_yg  <= 20'sd129 * g_ext;
    s1_yb  <= 20'sd25 * b_ext;
    s1_crr <= 20'sd112 * r_ext;
    s1_crg <= 20'sd94 * g_ext;
    s1_crb <= 20'sd18 * b_ext;
    s1_cbr <= 20'sd38 * r_ext;
    s1_cbg <= 20'sd74 * g_ext;
    s1_cbb <= 20'sd112 * b_ext;
    s2_x    <= s1_x;
    s2_y    <= s1_y;
    s2_r    <= s1_r;
    s2_g    <= s1_g;
    s2_b    <= s1_b;
    s2_luma <= y_full[7:0];  // low byte only
    s2_cr   <= cr_full[7:0];
    s2_cb   <= cb_full[7:0];
    out_x    <= s2_x;
    out_y    <= s2_y;
    out_mask <= pick_ok && (pick >= cfg.lower) && (pick <= cfg.upper);
  end

  assign mask_pix = '{valid: out_valid, mask: out_mask, x: out_x, y: out_y};

endmodule

/* hw/target_accum.sv */
module target_accum import tracker_pkg::*; (
  input  logic         clk_pixel,
  input  logic         sys_rst,
  input  mask_pix_t    mask_pix,
  input  logic         frame_end_d,
  output frame_stats_t stats,
  output logic         stats_valid
);

  frame_stats_t acc;   // running totals of the open frame
  frame_stats_t nxt;   // totals including this cycle's pixel
  frame_stats_t empty;
  logic         hit;

  assign hit = mask_pix.valid && mask_pix.mask;
  assign empty = '{count: '0, min_x: '1, min_y: '1, max_x: '0, max_y: '0,
                   x_sum: '0, y_sum: '0};

  always_comb begin
    nxt = acc;
    if (hit) begin
      if (mask_pix.x < acc.min_x) nxt.min_x = mask_pix.x;
      if (mask_pix.y < acc.min_y) nxt.min_y = mask_pix.y;
      if (mask_pix.x > acc.max_x) nxt.max_x = mask_pix.x;
      if (mask_pix.y > acc.max_y) nxt.max_y = mask_pix.y;
      nxt.count = acc.count + 1'b1;
      nxt.x_sum = acc.x_sum + sum_t'(mask_pix.x);
      nxt.y_sum = acc.y_sum + sum_t'(mask_pix.y);
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      acc         <= empty;
      stats_valid <= 1'b0;
    end else begin
      acc         <= frame_end_d ? empty : nxt;  // pixel on frame end closes with it
      stats_valid <= frame_end_d;
    end
  end

  // closed frame totals
  always_ff @(posedge clk_pixel) begin
    if (frame_end_d) stats <= nxt;
  end

endmodule

/* hw/com_divider.sv */
`include "tracker_defines.svh"

module com_divider import tracker_pkg::*; (
  input  logic   clk_pixel,
  input  logic   sys_rst,
  input  logic   div_start,
  input  sum_t   dividend,
  input  count_t divisor,
  output sum_t   quotient,
  output logic   div_done
);

  localparam int STEPS = `TRK_DIV_STEPS;
  localparam int CW    = `TRK_CNT_BITS;

  logic [$clog2(STEPS+1)-1:0] steps_left;
  logic                       busy;
  logic [CW-1:0]              rem, rem_in, rem_nxt;  // remainder stays below divisor
  logic [CW:0]                shifted;
  count_t                     den, den_r;
  sum_t                       quo_in, quo_nxt;

  // first step runs on the start edge itself, so done lands STEPS cycles later
  assign den    = div_start ? divisor : den_r;
  assign rem_in = div_start ? '0 : rem;
  assign quo_in = div_start ? dividend : quotient;

  always_comb begin
    shifted = {rem_in, quo_in[`TRK_SUM_BITS-1]};  // bring down next dividend bit
    quo_nxt = {quo_in[`TRK_SUM_BITS-2:0], 1'b0};
    rem_nxt = shifted[CW-1:0];
    if (shifted >= {1'b0, den}) begin  // restore is implicit, keep shifted otherwise
      rem_nxt    = CW'(shifted - {1'b0, den});
      quo_nxt[0] = 1'b1;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      busy       <= 1'b0;
      div_done   <= 1'b0;
      steps_left <= '0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        busy       <= 1'b1;
        steps_left <= ($clog2(STEPS+1))'(STEPS - 1);
      end else if (busy) begin
        steps_left <= steps_left - 1'b1;
        if (steps_left == 1) begin
          busy     <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (div_start || busy) begin
      rem      <= rem_nxt;
      quotient <= quo_nxt;
    end
    if (div_start) den_r <= divisor;
  end

endmodule

/* hw/frame_ctrl.sv */
module frame_ctrl import tracker_pkg::*; (
  input  logic          clk_pixel,
  input  logic          sys_rst,
  input  frame_stats_t  stats,
  input  logic          stats_valid,
  output logic          div_start,
  output sum_t          dividend,
  output count_t        divisor,
  input  sum_t          quotient,
  input  logic          div_done,
  output track_result_t result,
  output logic          result_valid,
  output logic          drop
);

  ctrl_state_t  state;
  frame_stats_t st;           // frame being worked on
  logic         take;         // stats accepted this cycle
  logic         empty_frame;

  assign take         = stats_valid && (state == IDLE);
  assign empty_frame  = (stats.count == '0);
  assign dividend     = (state == DIV_Y) ? st.y_sum : st.x_sum;  // div_start enters with state
  assign divisor      = st.count;
  assign result_valid = (state == PUBLISH);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state     <= IDLE;
      div_start <= 1'b0;
      drop      <= 1'b0;
    end else begin
      div_start <= 1'b0;
      drop      <= stats_valid && (state != IDLE);  // busy, frame is lost
      case (state)
        IDLE: begin
          if (take) begin
            if (empty_frame) begin
              state <= PUBLISH;  // nothing to divide
            end else begin
              state     <= DIV_X;
              div_start <= 1'b1;
            end
          end
        end
        DIV_X: begin
          if (div_done) begin
            state     <= DIV_Y;
            div_start <= 1'b1;  // reuse divider for y
          end
        end
        DIV_Y: if (div_done) state <= PUBLISH;
        default: state <= IDLE;  // PUBLISH lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (take) begin
      st           <= stats;
      result.count <= stats.count;
      result.min_x <= stats.min_x;
      result.min_y <= stats.min_y;
      result.max_x <= stats.max_x;
      result.max_y <= stats.max_y;
      result.empty <= empty_frame;
      result.com_x <= '0;
      result.com_y <= '0;
    end
    if (state == DIV_X && div_done) result.com_x <= xcoord_t'(quotient);  // truncated mean
    if (state == DIV_Y && div_done) result.com_y <= ycoord_t'(quotient);
  end

endmodule

/* hw/tracker_top.sv */
module tracker_top import tracker_pkg::*; (
  input  logic        clk_pixel,
  input  logic        sys_rst,
  input  pix_in_t     pix_in,     // camera pixel with its coordinate
  input  logic        frame_end,  // pulse after last pixel of a frame
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  track_cfg_t    cfg;           // channel select and bounds
  mask_pix_t     mask_pix;      // thresholded pixel stream
  logic          frame_end_d;   // frame end aligned to mask_pix
  frame_stats_t  stats;
  logic          stats_valid;
  logic          div_start;
  sum_t          dividend;
  count_t        divisor;
  sum_t          quotient;
  logic          div_done;
  track_result_t result;
  logic          result_valid;
  logic          drop;          // frame lost while busy

  apb_regs u_regs (
    .clk_pixel, .sys_rst,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .cfg, .result, .result_valid, .drop
  );

  channel_mask u_mask (
    .clk_pixel, .sys_rst,
    .cfg, .pix_in, .frame_end,
    .mask_pix, .frame_end_d
  );

  target_accum u_accum (
    .clk_pixel, .sys_rst,
    .mask_pix, .frame_end_d,
    .stats, .stats_valid
  );

  frame_ctrl u_ctrl (
    .clk_pixel, .sys_rst,
    .stats, .stats_valid,
    .div_start, .dividend, .divisor, .quotient, .div_done,
    .result, .result_valid, .drop
  );

  // shared by both center coordinates, x first then y
  com_divider u_div (
    .clk_pixel, .sys_rst,
    .div_start, .dividend, .divisor,
    .quotient, .div_done
  );

endmodule

/* bench/tb_tracker.sv */
`include "tracker_defines.svh"

module tb_tracker import tracker_pkg::*; ();

  logic        clk_pixel;
  logic        sys_rst;
  pix_in_t     pix_in;
  logic        frame_end;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // pending comparisons, one entry per register check or end-of-test marker
  string       test_q[$];
  string       sig_q[$];
  time         time_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] got_q[$];
  bit          last_q[$];

  string       cur_test;
  string       item_test;
  bit          item_last;
  int          errors = 0;
  int          test_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          timeouts = 0;
  logic [15:0] frame_rgb [0:11][0:15];  // 16 by 12 raster, rgb565
  int          x0;                       // raster origin in the frame
  int          y0;
  logic [7:0]  n_pub = 0;                // frames expected in STATUS
  logic [7:0]  n_drop = 0;

  tracker_top DUT (
    .clk_pixel, .sys_rst, .pix_in, .frame_end,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clk_pixel = 1'b0;
    forever #50 clk_pixel = ~clk_pixel;
  end

  // expected tracker result for the raster held in frame_rgb
  function automatic track_result_t reference_result(input logic [2:0] sel,
      input logic [7:0] lo, input logic [7:0] hi, input int xo, input int yo);
    track_result_t res;
    int r8, g8, b8, luma, cr, cb, chan, px, py, sx, sy;
    res = '0;
    res.min_x = '1;  // empty box, min at all ones
    res.min_y = '1;
    sx = 0;
    sy = 0;
    for (int row = 0; row < 12; row++) begin
      for (int col = 0; col < 16; col++) begin
        r8 = {frame_rgb[row][col][15:11], 3'b000};  // widen with zero lsbs
        g8 = {frame_rgb[row][col][10:5], 2'b00};
        b8 = {frame_rgb[row][col][4:0], 3'b000};
        luma = (16 + ((66 * r8 + 129 * g8 + 25 * b8 + 128) >>> 8)) & 255;
        cr = (128 + ((112 * r8 - 94 * g8 - 18 * b8 + 128) >>> 8)) & 255;
        cb = (128 + ((-38 * r8 - 74 * g8 + 112 * b8 + 128) >>> 8)) & 255;
        case (sel)
          3'd0: chan = g8;
          3'd1: chan = r8;
          3'd2: chan = b8;
          3'd4: chan = luma;
          3'd5: chan = cr;
          3'd6: chan = cb;
          default: chan = -1;  // codes 3 and 7 never pass
        endcase
        if (chan >= 0 && chan >= int'(lo) && chan <= int'(hi)) begin
          px = xo + col;
          py = yo + row;
          if (px < int'(res.min_x)) res.min_x = xcoord_t'(px);
          if (py < int'(res.min_y)) res.min_y = ycoord_t'(py);
          if (px > int'(res.max_x)) res.max_x = xcoord_t'(px);
          if (py > int'(res.max_y)) res.max_y = ycoord_t'(py);
          res.count = count_t'(int'(res.count) + 1);
          sx += px;
          sy += py;
        end
      end
    end
    res.empty = (res.count == 0);
    if (!res.empty) begin
      res.com_x = xcoord_t'(sx / int'(res.count));  // truncated mean
      res.com_y = ycoord_t'(sy / int'(res.count));
    end
    return res;
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
      output logic err);
    @(posedge clk_pixel);  // setup phase
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk_pixel);
    penable <= 1'b1;  // access phase
    @(negedge clk_pixel);
    err = pslverr;
    expect_word("pready", 32'd1, {31'd0, pready});  // no wait states
    @(posedge clk_pixel);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
      output logic err);
    @(posedge clk_pixel);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk_pixel);
    penable <= 1'b1;
    @(negedge clk_pixel);  // mid-cycle, prdata settled
    data = prdata;
    err  = pslverr;
    expect_word("pready", 32'd1, {31'd0, pready});
    @(posedge clk_pixel);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic expect_word(input string sig, input logic [31:0] exp,
      input logic [31:0] got);
    test_q.push_back(cur_test);
    sig_q.push_back(sig);
    time_q.push_back($time);  // sample time, not check time
    exp_q.push_back(exp);
    got_q.push_back(got);
    last_q.push_back(1'b0);
  endtask

  task automatic close_test();
    test_q.push_back(cur_test);
    sig_q.push_back("");
    time_q.push_back($time);
    exp_q.push_back('0);
    got_q.push_back('0);
    last_q.push_back(1'b1);
  endtask

  task automatic fill_frame();
    x0 = $urandom_range(600);
    y0 = $urandom_range(400);
    for (int row = 0; row < 12; row++) begin
      for (int col = 0; col < 16; col++) frame_rgb[row][col] = 16'($urandom());
    end
  endtask

  // one pixel per cycle, then frame_end; a second pulse two cycles later if asked
  task automatic send_frame(input bit double_end);
    for (int row = 0; row < 12; row++) begin
      for (int col = 0; col < 16; col++) begin
        @(posedge clk_pixel);
        pix_in <= '{valid: 1'b1, x: xcoord_t'(x0 + col), y: ycoord_t'(y0 + row),
                    rgb565: frame_rgb[row][col]};
      end
    end
    @(posedge clk_pixel);
    pix_in.valid <= 1'b0;
    frame_end    <= 1'b1;
    @(posedge clk_pixel);
    frame_end <= 1'b0;
    if (double_end) begin
      @(posedge clk_pixel);
      frame_end <= 1'b1;
      @(posedge clk_pixel);
      frame_end <= 1'b0;
    end
  endtask

  // poll STATUS until the published count reaches target
  task automatic wait_published(input logic [7:0] target);
    logic [31:0] st;
    logic        err;
    int          tries;
    tries = 0;
    apb_read(`TRK_ADDR_STATUS, st, err);
    while (st[7:0] != target && tries < 100) begin
      apb_read(`TRK_ADDR_STATUS, st, err);
      tries++;
    end
    if (st[7:0] != target) begin
      $display("timeout at %0t: frame %0d was never published", $time, target);
      timeouts++;
    end
  endtask

  task automatic check_result(input track_result_t e);
    logic [31:0] d;
    logic        err;
    apb_read(`TRK_ADDR_STATUS, d, err);
    expect_word("STATUS", {15'd0, e.empty, n_drop, n_pub}, d);
    apb_read(`TRK_ADDR_BOX_MIN, d, err);
    expect_word("BOX_MIN", {6'd0, e.min_y, 5'd0, e.min_x}, d);
    apb_read(`TRK_ADDR_BOX_MAX, d, err);
    expect_word("BOX_MAX", {6'd0, e.max_y, 5'd0, e.max_x}, d);
    apb_read(`TRK_ADDR_COM, d, err);
    expect_word("COM", {6'd0, e.com_y, 5'd0, e.com_x}, d);
    apb_read(`TRK_ADDR_COUNT, d, err);
    expect_word("COUNT", {11'd0, e.count}, d);
  endtask

  task automatic run_frame(input logic [2:0] sel, input logic [7:0] lo,
      input logic [7:0] hi);
    track_result_t exp;
    logic          err;
    apb_write(`TRK_ADDR_CTRL, {8'd0, hi, lo, 5'd0, sel}, err);
    expect_word("pslverr on CTRL write", 32'd0, {31'd0, err});
    fill_frame();
    exp = reference_result(sel, lo, hi, x0, y0);
    send_frame(1'b0);
    n_pub++;
    wait_published(n_pub);
    check_result(exp);
  endtask

  // compares queued samples away from the driving edge
  always @(negedge clk_pixel) begin
    while (last_q.size() > 0) begin
      item_test = test_q.pop_front();
      item_last = last_q.pop_front();
      if (item_last) begin
        void'(sig_q.pop_front());
        void'(time_q.pop_front());
        void'(exp_q.pop_front());
        void'(got_q.pop_front());
        tests_run++;
        if (test_errs == 0) begin
          $display("test %s: ok", item_test);
        end else begin
          tests_failed++;
          $display("test %s: %0d mismatches", item_test, test_errs);
        end
        test_errs = 0;
      end else begin
        assert (got_q[0] === exp_q[0]) else begin
          $display("error at %0t: %s expected 0x%08h, got 0x%08h",
                   time_q[0], sig_q[0], exp_q[0], got_q[0]);
          errors++;
          test_errs++;
        end
        void'(sig_q.pop_front());
        void'(time_q.pop_front());
        void'(exp_q.pop_front());
        void'(got_q.pop_front());
      end
    end
  end

  initial begin
    logic [31:0]   d;
    logic [31:0]   wr;
    logic          err;
    int            code;
    int            lo;
    int            hi;
    int            tries;
    track_result_t exp;
    void'($urandom(32'hd15e));
    sys_rst   <= 1'b1;
    pix_in    <= '0;
    frame_end <= 1'b0;
    paddr     <= '0;
    psel      <= 1'b0;
    penable   <= 1'b0;
    pwrite    <= 1'b0;
    pwdata    <= '0;
    repeat (8) @(posedge clk_pixel);
    sys_rst <= 1'b0;

    cur_test = "reset values";
    apb_read(`TRK_ADDR_CTRL, d, err);
    expect_word("CTRL", 32'd0, d);
    apb_read(`TRK_ADDR_STATUS, d, err);
    expect_word("STATUS", 32'd0, d);
    apb_read(8'h18, d, err);  // past the last register
    expect_word("pslverr on unmapped read", 32'd1, {31'd0, err});
    close_test();

    for (int i = 0; i < 6; i++) begin
      code = (i < 3) ? i : i + 1;  // 0, 1, 2, 4, 5, 6
      lo   = $urandom_range(160);
      hi   = lo + 40 + $urandom_range(60);
      if (hi > 255) hi = 255;
      cur_test = $sformatf("channel select %0d", code);
      run_frame(3'(code), 8'(lo), 8'(hi));
      close_test();
    end

    cur_test = "select code 3";
    run_frame(3'd3, 8'd0, 8'd255);
    close_test();
    cur_test = "lower above upper";
    run_frame(3'd4, 8'd200, 8'd100);
    close_test();

    cur_test = "ctrl readback and read-only count";
    wr = {8'd0, 8'($urandom()), 8'($urandom()), 5'd0, 3'($urandom())};
    apb_write(`TRK_ADDR_CTRL, wr, err);
    expect_word("pslverr on CTRL write", 32'd0, {31'd0, err});
    apb_read(`TRK_ADDR_CTRL, d, err);
    expect_word("CTRL", wr, d);
    apb_read(`TRK_ADDR_COUNT, wr, err);
    apb_write(`TRK_ADDR_COUNT, 32'h0001_2345, err);
    expect_word("pslverr on COUNT write", 32'd1, {31'd0, err});
    apb_read(`TRK_ADDR_COUNT, d, err);
    expect_word("COUNT", wr, d);  // write must not land
    close_test();

    cur_test = "frame dropped while busy";
    apb_write(`TRK_ADDR_CTRL, {8'd0, 8'd255, 8'd0, 5'd0, 3'd4}, err);  // luma, all pass
    fill_frame();
    exp = reference_result(3'd4, 8'd0, 8'd255, x0, y0);
    send_frame(1'b1);
    n_pub++;
    n_drop++;  // second pulse hits the divider
    wait_published(n_pub);
    check_result(exp);
    repeat (100) @(posedge clk_pixel);  // a second publish would show by now
    apb_read(`TRK_ADDR_STATUS, d, err);
    expect_word("STATUS", {15'd0, exp.empty, n_drop, n_pub}, d);
    close_test();

    tries = 0;
    while (last_q.size() > 0 && tries < 20) begin
      @(posedge clk_pixel);
      tries++;
    end
    if (last_q.size() > 0) begin
      $display("checker stalled with %0d comparisons still queued", last_q.size());
      timeouts++;
    end
    $display("tests %0d, failed %0d, mismatches %0d, timeouts %0d",
             tests_run, tests_failed, errors, timeouts);
    if (errors == 0 && tests_failed == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tracker.f */
+incdir+hw
hw/tracker_pkg.sv
hw/apb_regs.sv
hw/channel_mask.sv
hw/target_accum.sv
hw/com_divider.sv
hw/frame_ctrl.sv
hw/tracker_top.sv
bench/tb_tracker.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tracker.f --top-module tb_tracker

out=$(./obj_dir/Vtb_tracker)
echo "$out"

if grep -q "Verification passed" <<< "$out"; then
  exit 0
else
  exit 1
fi
